// File: include/udp_defines.svh
// Data path widths, port count, FIFO depths and module header layout
`ifndef UDP_DEFINES_SVH
`define UDP_DEFINES_SVH

// Word lanes
`define UDP_DATA_WIDTH 64
`define UDP_CTRL_WIDTH 8

// Port count and buffering
`define UDP_NUM_PORTS 4
`define UDP_IN_FIFO_DEPTH 4
`define UDP_OQ_DEPTH 16

// Module header word
`define UDP_IOQ_HDR_CTRL 8'hff
`define UDP_DST_LSB 48
`define UDP_SRC_LSB 16

`endif

// File: design/udp_data_pkg.sv
// Packet word, ctrl lane, port mask and port number types
`include "udp_defines.svh"

package udp_data_pkg;

   // ------------------------------
   // Word lanes
   // ------------------------------
   typedef logic [`UDP_DATA_WIDTH-1:0] data_word_t;
   typedef logic [`UDP_CTRL_WIDTH-1:0] ctrl_word_t;

   // ------------------------------
   // Port addressing
   // ------------------------------
   // One bit per output port
   typedef logic [`UDP_NUM_PORTS-1:0] port_mask_t;
   typedef logic [$clog2(`UDP_NUM_PORTS)-1:0] port_num_t;

endpackage

// File: design/udp_ctrl_pkg.sv
// State encodings for the input arbiter and the output port lookup
package udp_ctrl_pkg;

   // Arbiter waits for a non-empty input, then sends one whole packet
   typedef enum logic {
      IDLE,
      SEND
   } arb_state_t;

   // Lookup tracks whether the next word is a module header
   typedef enum logic {
      WAIT_HDR,
      IN_PKT
   } lut_state_t;

endpackage

// File: design/pkt_bus_if.sv
// Internal packet bus with data, ctrl, wr and rdy, plus src and dst modports
`timescale 1ns/10ps

interface pkt_bus_if import udp_data_pkg::*; ();

   data_word_t data;
   ctrl_word_t ctrl;
   logic       wr;
   logic       rdy;

   // Sender side
   modport src (
      output data,
      output ctrl,
      output wr,
      input  rdy
   );

   // Receiver side
   modport dst (
      input  data,
      input  ctrl,
      input  wr,
      output rdy
   );

endinterface

// File: design/pkt_fifo.sv
// Show-ahead FIFO of data and ctrl words with full and empty flags
`timescale 1ns/10ps

module pkt_fifo import udp_data_pkg::*; #(
   parameter int DEPTH = 4
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       wr_en,
   input  data_word_t wr_data,
   input  ctrl_word_t wr_ctrl,
   input  logic       rd_en,
   output data_word_t rd_data,
   output ctrl_word_t rd_ctrl,
   output logic       full,
   output logic       empty
);

   localparam int ADDR_W = $clog2(DEPTH);
   localparam int CNT_W  = $clog2(DEPTH + 1);

   data_word_t mem_data [DEPTH];
   ctrl_word_t mem_ctrl [DEPTH];
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   logic [CNT_W-1:0]  count;
   logic do_wr;
   logic do_rd;

   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);
   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   // Head word straight from storage
   assign rd_data = mem_data[rd_ptr];
   assign rd_ctrl = mem_ctrl[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem_data[wr_ptr] <= wr_data;
         mem_ctrl[wr_ptr] <= wr_ctrl;
      end
   end

   // ------------------------------
   // Pointers and occupancy
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// File: design/input_arbiter.sv
// Per-port input FIFOs and a round-robin whole-packet arbiter onto one bus
`timescale 1ns/10ps
`include "udp_defines.svh"

module input_arbiter import udp_data_pkg::*, udp_ctrl_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  data_word_t in_data [`UDP_NUM_PORTS],
   input  ctrl_word_t in_ctrl [`UDP_NUM_PORTS],
   input  port_mask_t in_wr,
   output port_mask_t in_rdy,
   pkt_bus_if.src     out
);

   data_word_t fifo_data [`UDP_NUM_PORTS];
   ctrl_word_t fifo_ctrl [`UDP_NUM_PORTS];
   port_mask_t fifo_full;
   port_mask_t fifo_empty;
   port_mask_t fifo_rd;

   arb_state_t state;
   port_num_t  rr_ptr;
   port_num_t  cur_port;
   port_num_t  pick;
   logic       found;
   logic       prev_zero;
   logic       pop;
   logic       out_valid;
   data_word_t out_data_q;
   ctrl_word_t out_ctrl_q;

   for (genvar i = 0; i < `UDP_NUM_PORTS; i++) begin : g_in_fifo
      pkt_fifo #(.DEPTH(`UDP_IN_FIFO_DEPTH)) in_fifo (
         .clk     (clk),
         .reset   (reset),
         .wr_en   (in_wr[i]),
         .wr_data (in_data[i]),
         .wr_ctrl (in_ctrl[i]),
         .rd_en   (fifo_rd[i]),
         .rd_data (fifo_data[i]),
         .rd_ctrl (fifo_ctrl[i]),
         .full    (fifo_full[i]),
         .empty   (fifo_empty[i])
      );
      assign fifo_rd[i] = pop && (cur_port == port_num_t'(i));
   end

   assign in_rdy = ~fifo_full;

   // Scan starts at the port after the last one served
   always_comb begin
      port_num_t idx;
      pick  = rr_ptr;
      found = 1'b0;
      for (int k = 0; k < `UDP_NUM_PORTS; k++) begin
         idx = rr_ptr + port_num_t'(k);
         if (!found && !fifo_empty[idx]) begin
            pick  = idx;
            found = 1'b1;
         end
      end
   end

   // Pop when the output register is free or drains this cycle
   assign pop = (state == SEND) && !fifo_empty[cur_port] && (!out_valid || out.rdy);

   // ------------------------------
   // Packet FSM
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= IDLE;
         rr_ptr    <= '0;
         cur_port  <= '0;
         prev_zero <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         if (pop) begin
            out_valid <= 1'b1;
         end else if (out.rdy) begin
            out_valid <= 1'b0;
         end
         case (state)
            IDLE: begin
               if (found) begin
                  cur_port  <= pick;
                  prev_zero <= 1'b0;
                  state     <= SEND;
               end
            end
            SEND: begin
               if (pop) begin
                  prev_zero <= (fifo_ctrl[cur_port] == '0);
                  // End of packet closes the grant
                  if (fifo_ctrl[cur_port] != '0 && prev_zero) begin
                     rr_ptr <= cur_port + 1'b1;
                     state  <= IDLE;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (pop) begin
         out_data_q <= fifo_data[cur_port];
         out_ctrl_q <= fifo_ctrl[cur_port];
      end
   end

   assign out.data = out_data_q;
   assign out.ctrl = out_ctrl_q;
   assign out.wr   = out_valid && out.rdy;

endmodule

// File: design/output_port_lookup.sv
// Single registered stage that writes the destination mask into each module header
`timescale 1ns/10ps
`include "udp_defines.svh"

module output_port_lookup import udp_data_pkg::*, udp_ctrl_pkg::*; (
   input  logic   clk,
   input  logic   reset,
   pkt_bus_if.dst in,
   pkt_bus_if.src out
);

   lut_state_t state;
   logic       is_hdr;
   port_num_t  src_port;
   port_mask_t dst_mask;
   data_word_t next_data;
   data_word_t out_data_q;
   ctrl_word_t out_ctrl_q;
   logic       out_valid;

   // Header only counts at a packet boundary
   assign is_hdr = (state == WAIT_HDR) && (in.ctrl == `UDP_IOQ_HDR_CTRL);

   // Ports pair up as 0/1 and 2/3
   assign src_port = in.data[`UDP_SRC_LSB +: $bits(port_num_t)];
   assign dst_mask = port_mask_t'(1) << (src_port ^ port_num_t'(1));

   always_comb begin
      next_data = in.data;
      if (is_hdr) begin
         next_data[`UDP_DST_LSB +: `UDP_NUM_PORTS] = dst_mask;
      end
   end

   // Stage stalls as a whole with the downstream
   assign in.rdy = out.rdy;

   // ------------------------------
   // Boundary tracking
   // ------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= WAIT_HDR;
         out_valid <= 1'b0;
      end else begin
         if (in.wr) begin
            out_valid <= 1'b1;
         end else if (out.rdy) begin
            out_valid <= 1'b0;
         end
         if (in.wr) begin
            case (state)
               WAIT_HDR: begin
                  if (in.ctrl == `UDP_IOQ_HDR_CTRL) begin
                     state <= IN_PKT;
                  end
               end
               // Header already taken, so any nonzero ctrl ends the packet
               IN_PKT: begin
                  if (in.ctrl != '0) begin
                     state <= WAIT_HDR;
                  end
               end
               default: state <= WAIT_HDR;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in.wr) begin
         out_data_q <= next_data;
         out_ctrl_q <= in.ctrl;
      end
   end

   assign out.data = out_data_q;
   assign out.ctrl = out_ctrl_q;
   assign out.wr   = out_valid && out.rdy;

endmodule

// File: design/output_queues.sv
// Per-port output FIFOs filled by destination mask and drained under per-port ready
`timescale 1ns/10ps
`include "udp_defines.svh"

module output_queues import udp_data_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   pkt_bus_if.dst     in,
   output data_word_t out_data [`UDP_NUM_PORTS],
   output ctrl_word_t out_ctrl [`UDP_NUM_PORTS],
   output port_mask_t out_wr,
   input  port_mask_t out_rdy
);

   port_mask_t oq_full;
   port_mask_t oq_empty;
   port_mask_t oq_wr;
   port_mask_t mask_q;
   port_mask_t wr_mask;
   logic       is_hdr;

   assign is_hdr = (in.ctrl == `UDP_IOQ_HDR_CTRL);

   // Header carries its own mask, the rest of the packet uses the latched one
   assign wr_mask = is_hdr ? in.data[`UDP_DST_LSB +: `UDP_NUM_PORTS] : mask_q;
   assign oq_wr   = wr_mask & {`UDP_NUM_PORTS{in.wr}};

   always_ff @(posedge clk) begin
      if (reset) begin
         mask_q <= '0;
      end else if (in.wr && is_hdr) begin
         mask_q <= in.data[`UDP_DST_LSB +: `UDP_NUM_PORTS];
      end
   end

   // Any full queue blocks the whole bus so nothing is dropped
   assign in.rdy = ~|oq_full;

   // ------------------------------
   // Queues
   // ------------------------------
   for (genvar i = 0; i < `UDP_NUM_PORTS; i++) begin : g_oq
      pkt_fifo #(.DEPTH(`UDP_OQ_DEPTH)) oq_fifo (
         .clk     (clk),
         .reset   (reset),
         .wr_en   (oq_wr[i]),
         .wr_data (in.data),
         .wr_ctrl (in.ctrl),
         .rd_en   (out_wr[i]),
         .rd_data (out_data[i]),
         .rd_ctrl (out_ctrl[i]),
         .full    (oq_full[i]),
         .empty   (oq_empty[i])
      );
      assign out_wr[i] = !oq_empty[i] && out_rdy[i];
   end

endmodule

// File: design/user_data_path.sv
// Data path top with per-port ports, input arbiter, output port lookup and output queues
`timescale 1ns/10ps
`include "udp_defines.svh"

module user_data_path import udp_data_pkg::*; (
   input  logic       clk,
   input  logic       reset,

   input  data_word_t in_data_0,
   input  ctrl_word_t in_ctrl_0,
   input  logic       in_wr_0,
   output logic       in_rdy_0,
   input  data_word_t in_data_1,
   input  ctrl_word_t in_ctrl_1,
   input  logic       in_wr_1,
   output logic       in_rdy_1,
   input  data_word_t in_data_2,
   input  ctrl_word_t in_ctrl_2,
   input  logic       in_wr_2,
   output logic       in_rdy_2,
   input  data_word_t in_data_3,
   input  ctrl_word_t in_ctrl_3,
   input  logic       in_wr_3,
   output logic       in_rdy_3,

   output data_word_t out_data_0,
   output ctrl_word_t out_ctrl_0,
   output logic       out_wr_0,
   input  logic       out_rdy_0,
   output data_word_t out_data_1,
   output ctrl_word_t out_ctrl_1,
   output logic       out_wr_1,
   input  logic       out_rdy_1,
   output data_word_t out_data_2,
   output ctrl_word_t out_ctrl_2,
   output logic       out_wr_2,
   input  logic       out_rdy_2,
   output data_word_t out_data_3,
   output ctrl_word_t out_ctrl_3,
   output logic       out_wr_3,
   input  logic       out_rdy_3
);

   data_word_t in_data_a  [`UDP_NUM_PORTS];
   ctrl_word_t in_ctrl_a  [`UDP_NUM_PORTS];
   data_word_t out_data_a [`UDP_NUM_PORTS];
   ctrl_word_t out_ctrl_a [`UDP_NUM_PORTS];
   port_mask_t in_wr_v;
   port_mask_t in_rdy_v;
   port_mask_t out_wr_v;
   port_mask_t out_rdy_v;

   // ------------------------------
   // Port packing
   // ------------------------------
   assign in_data_a = '{in_data_0, in_data_1, in_data_2, in_data_3};
   assign in_ctrl_a = '{in_ctrl_0, in_ctrl_1, in_ctrl_2, in_ctrl_3};
   assign in_wr_v   = {in_wr_3, in_wr_2, in_wr_1, in_wr_0};
   assign {in_rdy_3, in_rdy_2, in_rdy_1, in_rdy_0} = in_rdy_v;

   assign out_rdy_v = {out_rdy_3, out_rdy_2, out_rdy_1, out_rdy_0};
   assign {out_wr_3, out_wr_2, out_wr_1, out_wr_0} = out_wr_v;
   assign out_data_0 = out_data_a[0];
   assign out_data_1 = out_data_a[1];
   assign out_data_2 = out_data_a[2];
   assign out_data_3 = out_data_a[3];
   assign out_ctrl_0 = out_ctrl_a[0];
   assign out_ctrl_1 = out_ctrl_a[1];
   assign out_ctrl_2 = out_ctrl_a[2];
   assign out_ctrl_3 = out_ctrl_a[3];

   // ------------------------------
   // Pipeline
   // ------------------------------
   pkt_bus_if arb_bus ();
   pkt_bus_if oq_bus ();

   input_arbiter input_arbiter_inst (
      .clk     (clk),
      .reset   (reset),
      .in_data (in_data_a),
      .in_ctrl (in_ctrl_a),
      .in_wr   (in_wr_v),
      .in_rdy  (in_rdy_v),
      .out     (arb_bus.src)
   );

   output_port_lookup output_port_lookup_inst (
      .clk   (clk),
      .reset (reset),
      .in    (arb_bus.dst),
      .out   (oq_bus.src)
   );

   output_queues output_queues_inst (
      .clk      (clk),
      .reset    (reset),
      .in       (oq_bus.dst),
      .out_data (out_data_a),
      .out_ctrl (out_ctrl_a),
      .out_wr   (out_wr_v),
      .out_rdy  (out_rdy_v)
   );

endmodule

// File: sim/udp_properties.sv
// Bound checks on output writes, reset quiet period and input ready levels
`timescale 1ns/10ps

module udp_properties import udp_data_pkg::*; (
   input logic       clk,
   input logic       reset,
   input port_mask_t in_rdy,
   input port_mask_t out_wr,
   input port_mask_t out_rdy
);

   // A queue only drains into a ready output
   wr_needs_rdy: assert property (@(posedge clk) disable iff (reset)
      (out_wr & ~out_rdy) == '0)
      else $error("out_wr high on a port whose out_rdy is low");

   // Outputs stay quiet in reset and in the first cycle after it
   quiet_in_reset: assert property (@(posedge clk) reset |-> out_wr == '0)
      else $error("out_wr high during reset");

   quiet_after_reset: assert property (@(posedge clk) reset |=> out_wr == '0)
      else $error("out_wr high in the cycle after reset");

   // Input ready must be a clean level once running
   rdy_known: assert property (@(posedge clk) disable iff (reset) !$isunknown(in_rdy))
      else $error("in_rdy has an unknown bit after reset");

endmodule

// File: sim/user_data_path_tb.sv
// Testbench for the data path: clock, reset, packet driver, output monitors and directed tests
`timescale 1ns/10ps
`include "udp_defines.svh"

module user_data_path_tb import udp_data_pkg::*; ();

   localparam int NP      = `UDP_NUM_PORTS;
   localparam int TIMEOUT = 400;
   localparam int TX_MAX  = 64;
   localparam int RX_MAX  = 256;
   // Longer than the 22 words of buffering between input 0 and output 1
   localparam int BP_LEN  = 24;

   logic       clk;
   logic       reset;
   data_word_t in_data [NP];
   ctrl_word_t in_ctrl [NP];
   port_mask_t in_wr;
   port_mask_t in_rdy;
   data_word_t out_data [NP];
   ctrl_word_t out_ctrl [NP];
   port_mask_t out_wr;
   port_mask_t out_rdy;

   integer     seed;
   data_word_t tx_data [NP][TX_MAX];
   ctrl_word_t tx_ctrl [NP][TX_MAX];
   int         tx_len [NP];
   data_word_t rx_data [NP][RX_MAX];
   ctrl_word_t rx_ctrl [NP][RX_MAX];
   int         rx_count [NP];
   int         rx_base [NP];

   user_data_path user_data_path_inst (
      .clk        (clk),
      .reset      (reset),
      .in_data_0  (in_data[0]),
      .in_ctrl_0  (in_ctrl[0]),
      .in_wr_0    (in_wr[0]),
      .in_rdy_0   (in_rdy[0]),
      .in_data_1  (in_data[1]),
      .in_ctrl_1  (in_ctrl[1]),
      .in_wr_1    (in_wr[1]),
      .in_rdy_1   (in_rdy[1]),
      .in_data_2  (in_data[2]),
      .in_ctrl_2  (in_ctrl[2]),
      .in_wr_2    (in_wr[2]),
      .in_rdy_2   (in_rdy[2]),
      .in_data_3  (in_data[3]),
      .in_ctrl_3  (in_ctrl[3]),
      .in_wr_3    (in_wr[3]),
      .in_rdy_3   (in_rdy[3]),
      .out_data_0 (out_data[0]),
      .out_ctrl_0 (out_ctrl[0]),
      .out_wr_0   (out_wr[0]),
      .out_rdy_0  (out_rdy[0]),
      .out_data_1 (out_data[1]),
      .out_ctrl_1 (out_ctrl[1]),
      .out_wr_1   (out_wr[1]),
      .out_rdy_1  (out_rdy[1]),
      .out_data_2 (out_data[2]),
      .out_ctrl_2 (out_ctrl[2]),
      .out_wr_2   (out_wr[2]),
      .out_rdy_2  (out_rdy[2]),
      .out_data_3 (out_data[3]),
      .out_ctrl_3 (out_ctrl[3]),
      .out_wr_3   (out_wr[3]),
      .out_rdy_3  (out_rdy[3])
   );

   bind user_data_path udp_properties udp_properties_inst (
      .clk     (clk),
      .reset   (reset),
      .in_rdy  ({in_rdy_3, in_rdy_2, in_rdy_1, in_rdy_0}),
      .out_wr  ({out_wr_3, out_wr_2, out_wr_1, out_wr_0}),
      .out_rdy ({out_rdy_3, out_rdy_2, out_rdy_1, out_rdy_0})
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Sample outputs mid-cycle so each word seen is the one taken on the next edge
   always @(negedge clk) begin
      for (int q = 0; q < NP; q++) begin
         if (reset) begin
            rx_count[q] = 0;
         end else if (out_wr[q] && rx_count[q] < RX_MAX) begin
            rx_data[q][rx_count[q]] = out_data[q];
            rx_ctrl[q][rx_count[q]] = out_ctrl[q];
            rx_count[q] = rx_count[q] + 1;
         end
      end
   end

   // ------------------------------
   // Reference model
   // ------------------------------
   function automatic int paired_port(input int port);
      case (port)
         0: return 1;
         1: return 0;
         2: return 3;
         default: return 2;
      endcase
   endfunction

   // Header gets a one-hot mask of the paired port and the rest stays as sent
   function automatic data_word_t expected_word(input int src, input int idx);
      data_word_t w;
      w = tx_data[src][idx];
      if (tx_ctrl[src][idx] == `UDP_IOQ_HDR_CTRL) begin
         w[`UDP_DST_LSB +: NP] = port_mask_t'(1) << paired_port(src);
      end
      return w;
   endfunction

   task automatic report_mismatch(input string name, input string what,
                                  input data_word_t expected, input data_word_t actual);
      $display("ERROR %s: %s expected %h actual %h", name, what, expected, actual);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out waiting for %s", what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic start_test();
      for (int q = 0; q < NP; q++) begin
         tx_len[q]  = 0;
         rx_base[q] = rx_count[q];
      end
   endtask

   // Header, zero-ctrl payload, then a nonzero end word
   task automatic add_packet(input int port, input int len);
      int base;
      base = tx_len[port];
      for (int i = 0; i < len; i++) begin
         tx_data[port][base + i] = {$random(seed), $random(seed)};
         if (i == 0) begin
            tx_data[port][base][`UDP_SRC_LSB +: 8] = 8'(port);
            tx_ctrl[port][base] = `UDP_IOQ_HDR_CTRL;
         end else if (i == len - 1) begin
            tx_ctrl[port][base + i] = 8'h04;
         end else begin
            tx_ctrl[port][base + i] = 8'h00;
         end
      end
      tx_len[port] = base + len;
   endtask

   // ------------------------------
   // Driver and checkers
   // ------------------------------
   task automatic send_stream(input int port);
      int waited;
      for (int i = 0; i < tx_len[port]; i++) begin
         waited = 0;
         while (!in_rdy[port]) begin
            in_wr[port] = 1'b0;
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
               report_timeout($sformatf("in_rdy_%0d to take word %0d", port, i));
            end
         end
         in_data[port] = tx_data[port][i];
         in_ctrl[port] = tx_ctrl[port][i];
         in_wr[port]   = 1'b1;
         @(posedge clk);
         #1;
      end
      in_wr[port] = 1'b0;
   endtask

   task automatic check_output(input string name, input int src);
      int dst;
      int waited;
      data_word_t exp_data;
      data_word_t got_data;
      dst = paired_port(src);
      waited = 0;
      while (rx_count[dst] - rx_base[dst] < tx_len[src]) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > TIMEOUT) begin
            report_timeout($sformatf("end of packet on output %0d", dst));
         end
      end
      for (int i = 0; i < tx_len[src]; i++) begin
         exp_data = expected_word(src, i);
         got_data = rx_data[dst][rx_base[dst] + i];
         assert (got_data === exp_data) else begin
            report_mismatch(name, $sformatf("out_data_%0d word %0d", dst, i),
                            exp_data, got_data);
         end
         assert (rx_ctrl[dst][rx_base[dst] + i] === tx_ctrl[src][i]) else begin
            report_mismatch(name, $sformatf("out_ctrl_%0d word %0d", dst, i),
                            data_word_t'(tx_ctrl[src][i]),
                            data_word_t'(rx_ctrl[dst][rx_base[dst] + i]));
         end
      end
   endtask

   // No stray words on any output once traffic has settled
   task automatic check_idle(input string name);
      int got;
      repeat (20) @(posedge clk);
      #1;
      for (int q = 0; q < NP; q++) begin
         got = rx_count[q] - rx_base[q];
         assert (got == tx_len[paired_port(q)]) else begin
            report_mismatch(name, $sformatf("word count on output %0d", q),
                            data_word_t'(tx_len[paired_port(q)]), data_word_t'(got));
         end
      end
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------
   task automatic test_reset();
      assert (out_wr == 4'b0000) else begin
         report_mismatch("test_reset", "out_wr", '0, data_word_t'(out_wr));
      end
      assert (in_rdy == 4'b1111) else begin
         report_mismatch("test_reset", "in_rdy", data_word_t'(4'b1111), data_word_t'(in_rdy));
      end
   endtask

   task automatic test_single();
      start_test();
      add_packet(0, 6);
      send_stream(0);
      check_output("test_single", 0);
      check_idle("test_single");
   endtask

   task automatic test_pairs();
      start_test();
      add_packet(1, 4);
      add_packet(2, 5);
      add_packet(3, 7);
      for (int p = 1; p < NP; p++) begin
         send_stream(p);
         check_output("test_pairs", p);
      end
      check_idle("test_pairs");
   endtask

   // Two packets per input, so each output also shows ordering
   task automatic test_contention();
      start_test();
      for (int p = 0; p < NP; p++) begin
         add_packet(p, 3 + p);
         add_packet(p, 8 - p);
      end
      fork
         send_stream(0);
         send_stream(1);
         send_stream(2);
         send_stream(3);
      join
      for (int p = 0; p < NP; p++) begin
         check_output("test_contention", p);
      end
      check_idle("test_contention");
   endtask

   task automatic test_backpressure();
      int waited;
      start_test();
      add_packet(0, BP_LEN);
      out_rdy[1] = 1'b0;
      fork
         send_stream(0);
         begin
            waited = 0;
            while (in_rdy[0]) begin
               assert (!out_wr[1]) else begin
                  report_mismatch("test_backpressure", "out_wr_1", '0, data_word_t'(out_wr[1]));
               end
               @(posedge clk);
               #1;
               waited++;
               if (waited > TIMEOUT) begin
                  report_timeout("in_rdy_0 to fall with out_rdy_1 low");
               end
            end
            repeat (4) begin
               assert (!out_wr[1]) else begin
                  report_mismatch("test_backpressure", "out_wr_1", '0, data_word_t'(out_wr[1]));
               end
               @(posedge clk);
               #1;
            end
            out_rdy[1] = 1'b1;
         end
      join
      check_output("test_backpressure", 0);
      check_idle("test_backpressure");
   endtask

   initial begin
      seed    = 32'h77a747c1;
      reset   = 1'b1;
      in_wr   = '0;
      out_rdy = '1;
      for (int p = 0; p < NP; p++) begin
         in_data[p] = '0;
         in_ctrl[p] = '0;
         tx_len[p]  = 0;
         rx_base[p] = 0;
      end
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      test_reset();
      test_single();
      test_pairs();
      test_contention();
      test_backpressure();
      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: list.f
+incdir+include
design/udp_data_pkg.sv
design/udp_ctrl_pkg.sv
design/pkt_bus_if.sv
design/pkt_fifo.sv
design/input_arbiter.sv
design/output_port_lookup.sv
design/output_queues.sv
design/user_data_path.sv
sim/udp_properties.sv
sim/user_data_path_tb.sv

// File: run.sh
#!/bin/sh
# Build the data path testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f list.f --top-module user_data_path_tb -o udp_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/udp_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -q '^TEST PASSED$'; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
